// ==== all.f ====
+incdir+verification
source/cpu_pkg.sv
source/fetch_unit.sv
source/decode_unit.sv
source/execute_unit.sv
source/memory_unit.sv
source/cpu.sv
verification/clock_gen.sv
verification/cpu_tb.sv

// ==== Makefile ====
SOURCES := all.f $(wildcard source/*.sv) $(wildcard verification/*.sv verification/*.svh)

.PHONY: all run clean

all: obj_dir/Vcpu_tb

obj_dir/Vcpu_tb: $(SOURCES)
	verilator --binary --timing --assert --x-initial 0 --x-assign 0 \
		-f all.f --top-module cpu_tb -o Vcpu_tb

run: obj_dir/Vcpu_tb
	./obj_dir/Vcpu_tb

clean:
	rm -rf obj_dir

// ==== verification/tb_model.svh ====
`ifndef tb_model_svh
`define tb_model_svh

//////////////////////////////
// Random source
//////////////////////////////
logic [31:0] lfsr_state = 32'h5b5a_48e3;

// Galois LFSR, right shift, one output bit per step
function automatic logic next_bit();
  logic out_bit;
  out_bit    = lfsr_state[0];
  lfsr_state = lfsr_state >> 1;
  if (out_bit) lfsr_state = lfsr_state ^ 32'hd000_0001; // Taps 32, 31, 29, 1
  return out_bit;
endfunction

function automatic logic [15:0] rand_bits(int n);
  logic [15:0] value;
  value = '0;
  for (int i = 0; i < n; i++) begin
    value = {value[14:0], next_bit()};
  end
  return value;
endfunction

//////////////////////////////
// Program generator
//////////////////////////////
logic [15:0] prog [256];       // Words to load through the boot port
int          prog_len;

function automatic void emit(logic [15:0] w);
  prog[prog_len] = w;
  prog_len++;
endfunction

function automatic void add_nops(int n);
  repeat (n) emit(16'h0000);   // ADD r0, r0, r0
endfunction

// LLB r0 retires nothing and leaves the flags alone
function automatic void add_quiet(int n);
  repeat (n) emit({cpu_pkg::op_llb, 4'd0, 8'h00});
endfunction

// ADD, SUB or XOR; destination never r15, which holds BR targets
function automatic logic [15:0] random_alu_word();
  logic [3:0] op;
  logic [3:0] rd;
  logic [3:0] rs;
  logic [3:0] rt;
  op = 4'(rand_bits(2) % 16'd3);
  rd = 4'(rand_bits(4) % 16'd15);
  rs = 4'(rand_bits(4));
  rt = 4'(rand_bits(4));
  return {op, rd, rs, rt};
endfunction

function automatic void add_segment(int kind);
  logic [15:0] target;
  logic [3:0]  base;
  logic [3:0]  off;
  int          start;
  start = prog_len;
  case (kind)
    0: emit(random_alu_word());
    1: emit({4'(16'd4 + rand_bits(2) % 16'd3), 4'(rand_bits(4) % 16'd15),
             4'(rand_bits(4)), 4'(rand_bits(4))});            // SLL, SRA, ROR
    2: emit({(rand_bits(1) == 16'd1) ? cpu_pkg::op_lhb : cpu_pkg::op_llb,
             4'(rand_bits(4) % 16'd15), 8'(rand_bits(8))});
    3: begin
      base = 4'(rand_bits(4));
      off  = 4'(rand_bits(4));
      emit({cpu_pkg::op_sw, 4'(rand_bits(4)), base, off});
      add_nops(3);
      emit({cpu_pkg::op_lw, 4'(rand_bits(4) % 16'd15), base, off}); // Same address
    end
    default: begin
      if (kind == 5) begin
        target = 16'((start + 18) * 2);                       // Byte address of target block
        emit({cpu_pkg::op_llb, 4'd15, target[7:0]});
        add_nops(3);
        emit({cpu_pkg::op_lhb, 4'd15, target[15:8]});
        add_nops(3);
      end
      emit(random_alu_word());                                // Sets the flags
      add_quiet(3);
      if (kind == 4) emit({cpu_pkg::op_b, 3'(rand_bits(3)), 9'd5});
      else           emit({cpu_pkg::op_br, 3'(rand_bits(3)), 1'b0, 4'd15, 4'd0});
      emit(random_alu_word());                                // Delay slot
      add_nops(3);
      emit(random_alu_word());                                // Skipped when taken
    end
  endcase
  add_nops(3);                                                // Also the branch target
endfunction

function automatic int pick_kind(int prog_index);
  case (prog_index)
    0:       return (rand_bits(2) == 16'd0) ? 2 : 0;          // Arithmetic, some byte loads
    1:       return 1 + int'(rand_bits(1));                   // Shifts and byte loads
    2:       return 3;                                        // Memory
    3:       return 4 + int'(rand_bits(1));                   // Branches
    default: return int'(rand_bits(3) % 16'd6);
  endcase
endfunction

function automatic void build_program(int prog_index);
  prog_len = 0;
  repeat (10) add_segment(pick_kind(prog_index));
  emit({cpu_pkg::op_hlt, 12'h000});
endfunction

//////////////////////////////
// ISA reference
//////////////////////////////
logic [15:0] model_regs [16] = '{default: 16'h0000}; // Kept across programs
logic [15:0] model_mem [256] = '{default: 16'h0000};
logic        mz, mv, mn;
logic [19:0] expect_q [$];                            // {dst_reg, data}

function automatic logic cond_met(logic [2:0] c);
  case (c)
    cpu_pkg::cond_ne: return !mz;
    cpu_pkg::cond_eq: return mz;
    cpu_pkg::cond_gt: return !mz && !mn;
    cpu_pkg::cond_lt: return mn;
    cpu_pkg::cond_ge: return mz || !mn;
    cpu_pkg::cond_le: return mz || mn;
    cpu_pkg::cond_ov: return mv;
    default:          return 1'b1;
  endcase
endfunction

// Runs the loaded program in order with one delay slot per branch
function automatic logic run_reference();
  logic [15:0] pc_b, w, a, b, d, r, addr, target, jump_to;
  logic [3:0]  op, rd;
  logic        write_reg, taken, jump_pending;
  int          steps;
  mz = 1'b0;                                          // Boot clears the flags
  mv = 1'b0;
  mn = 1'b0;
  pc_b = '0;
  jump_to = '0;
  jump_pending = 1'b0;
  for (steps = 0; steps < 1000; steps++) begin
    w  = prog[pc_b[8:1]];
    op = w[15:12];
    rd = w[11:8];
    a  = model_regs[w[7:4]];
    b  = model_regs[w[3:0]];
    d  = model_regs[rd];
    addr   = a + {{11{w[3]}}, w[3:0], 1'b0};
    target = '0;
    r = '0;
    write_reg = 1'b1;
    taken = 1'b0;
    case (op)
      cpu_pkg::op_add: begin
        r  = a + b;
        mv = (a[15] == b[15]) && (r[15] != a[15]);
        mn = r[15];
        mz = (r == 16'h0);
      end
      cpu_pkg::op_sub: begin
        r  = a - b;
        mv = (a[15] != b[15]) && (r[15] != a[15]);
        mn = r[15];
        mz = (r == 16'h0);
      end
      cpu_pkg::op_xor: begin
        r  = a ^ b;
        mz = (r == 16'h0);
      end
      cpu_pkg::op_sll: begin
        r  = a << w[3:0];
        mz = (r == 16'h0);
      end
      cpu_pkg::op_sra: begin
        r  = 16'($signed(a) >>> w[3:0]);
        mz = (r == 16'h0);
      end
      cpu_pkg::op_ror: begin
        r = a;
        repeat (w[3:0]) r = {r[0], r[15:1]};          // One bit at a time
        mz = (r == 16'h0);
      end
      cpu_pkg::op_lw:  r = model_mem[addr[8:1]];
      cpu_pkg::op_llb: r = {d[15:8], w[7:0]};
      cpu_pkg::op_lhb: r = {w[7:0], d[7:0]};
      cpu_pkg::op_sw: begin
        write_reg = 1'b0;
        model_mem[addr[8:1]] = d;
      end
      cpu_pkg::op_b: begin
        write_reg = 1'b0;
        taken  = cond_met(w[11:9]);
        target = pc_b + 16'd2 + {{6{w[8]}}, w[8:0], 1'b0};
      end
      cpu_pkg::op_br: begin
        write_reg = 1'b0;
        taken  = cond_met(w[11:9]);
        target = {a[15:1], 1'b0};
      end
      cpu_pkg::op_hlt: return 1'b1;
      default:         return 1'b0;                   // Generator never emits these
    endcase
    if (write_reg && rd != 4'd0) begin
      model_regs[rd] = r;
      expect_q.push_back({rd, r});
    end
    if (jump_pending) begin
      pc_b = jump_to;                                 // Delay slot done
      jump_pending = 1'b0;
    end else begin
      pc_b = pc_b + 16'd2;
    end
    if (taken) begin
      jump_pending = 1'b1;
      jump_to = target;
    end
  end
  return 1'b0;                                        // Never reached HLT
endfunction

`endif

// ==== verification/cpu_tb.sv ====
module cpu_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int prog_count      = 6;
  localparam int cycles_per_prog = 300;
  localparam int drain_cycles    = 20;
  localparam int cycle_limit     = 10 + prog_count
                                 * (cycles_per_prog + drain_cycles + cpu_pkg::mem_words + 4);

  logic                clk, reset;
  logic                boot, imem_we;
  logic [7:0]          imem_addr;
  logic [15:0]         imem_data;
  logic                hlt;
  logic [15:0]         pc;
  cpu_pkg::writeback_t wb;

  string       test_name = "reset";
  int          cycle_count = 0;
  logic [19:0] expected;       // Head of the writeback queue
  logic [15:0] held_pc;

  `include "tb_model.svh"

  clock_gen clocks (.clk, .reset);

  cpu DUT (
    .clk, .reset, .boot,
    .imem_we, .imem_addr, .imem_data,
    .hlt, .pc, .wb
  );

  //////////////////////////////
  // Failure reporting
  //////////////////////////////
  task automatic halt_run(string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped");
  endtask

  task automatic report_mismatch(string field, logic [15:0] exp_v, logic [15:0] act_v);
    halt_run($sformatf("Error %s %s expected %h actual %h", test_name, field, exp_v, act_v));
  endtask

  task automatic drive_slot();
    @(posedge clk);
    #1;                        // Inputs change 1 ns after the edge
  endtask

  // Every retired write against the model at the falling edge
  always @(negedge clk) begin
    if (!reset && wb.valid) begin
      if (expect_q.size() == 0) begin
        halt_run($sformatf("%s: writeback to r%0d with nothing left to retire",
                           test_name, wb.dst_reg));
      end else begin
        expected = expect_q.pop_front();
        assert (wb.dst_reg == expected[19:16])
          else report_mismatch("dst_reg", {12'h000, expected[19:16]}, {12'h000, wb.dst_reg});
        assert (wb.data == expected[15:0])
          else report_mismatch("data", expected[15:0], wb.data);
      end
    end
  end

  // Hang guard
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count == cycle_limit) halt_run("timeout: cycle limit reached");
  end

  //////////////////////////////
  // One program: load, run, halt
  //////////////////////////////
  task automatic load_and_run(int prog_index);
    logic ok;
    int   waited;
    test_name = $sformatf("program_%0d", prog_index);
    build_program(prog_index);
    ok = run_reference();
    assert (ok) else halt_run("reference model did not reach HLT");
    drive_slot();
    boot = 1'b1;
    for (int i = 0; i < prog_len; i++) begin
      imem_we   = 1'b1;
      imem_addr = 8'(i);
      imem_data = prog[i];
      drive_slot();
    end
    imem_we = 1'b0;
    drive_slot();
    boot = 1'b0;
    @(negedge clk);
    assert (!hlt) else halt_run("hlt high after boot");
    assert (pc == 16'h0000) else report_mismatch("pc_after_boot", 16'h0000, pc);
    assert (!wb.valid) else halt_run("writeback right after boot");
    waited = 0;
    while (!hlt) begin
      @(negedge clk);
      waited++;
      if (waited > cycles_per_prog) halt_run("program did not halt in time");
    end
    held_pc = pc;
    repeat (drain_cycles) begin // Pipeline drains and stays quiet
      @(negedge clk);
      assert (hlt) else halt_run("hlt dropped while halted");
      assert (pc == held_pc) else report_mismatch("halted_pc", held_pc, pc);
    end
    assert (expect_q.size() == 0) else halt_run("writebacks missing after halt");
  endtask

  initial begin
    boot      = 1'b1;
    imem_we   = 1'b0;
    imem_addr = 8'h00;
    imem_data = 16'h0000;
    @(negedge clk);
    while (reset) @(negedge clk);
    assert (!hlt) else halt_run("hlt high after reset");
    assert (pc == 16'h0000) else report_mismatch("pc_after_reset", 16'h0000, pc);
    assert (!wb.valid) else halt_run("writeback right after reset");
    for (int p = 0; p < prog_count; p++) begin
      load_and_run(p);
    end
    if (expect_q.size() == 0) begin
      $display("=== PASS ===");
      $finish;
    end else begin
      halt_run("writebacks left over at the end");
    end
  end

endmodule

// ==== verification/clock_gen.sv ====
module clock_gen (
  output logic clk,
  output logic reset
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk; // 10 ns period
  end

  initial begin
    reset = 1'b1;
    repeat (10) @(posedge clk);
    #1 reset = 1'b0; // Released just after an edge, like the other inputs
  end

endmodule

// ==== source/cpu.sv ====
module cpu (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  boot,
  input  logic                  imem_we,
  input  logic [7:0]            imem_addr,
  input  logic [15:0]           imem_data,
  output logic                  hlt,
  output logic [15:0]           pc,
  output cpu_pkg::writeback_t   wb
);

  cpu_pkg::fetch_out_t    fetch_out;   // F/D
  cpu_pkg::decode_out_t   decode_out;  // D/E
  cpu_pkg::execute_out_t  execute_out; // E/M
  cpu_pkg::flags_t        flags;       // Z, V, N back to decode
  logic                   redirect;
  logic [15:0]            redirect_pc;

  //////////////////////////////
  // Stages
  //////////////////////////////
  fetch_unit fetch (
    .clk, .reset, .boot,
    .imem_we, .imem_addr, .imem_data,
    .redirect, .redirect_pc,
    .freeze    (hlt),          // Halt flag stops the PC
    .pc,
    .fetch_out
  );

  decode_unit decode (
    .clk, .reset, .boot,
    .fetch_out, .flags, .wb,   // wb writes the register file
    .redirect, .redirect_pc,
    .freeze    (hlt),
    .decode_out
  );

  execute_unit execute (
    .clk, .reset, .boot,
    .decode_out,
    .flags,
    .execute_out
  );

  memory_unit memory (
    .clk, .reset,
    .execute_out,
    .wb                        // Also the top-level port
  );

endmodule

// ==== source/memory_unit.sv ====
module memory_unit (
  input  logic                      clk,
  input  logic                      reset,
  input  cpu_pkg::execute_out_t     execute_out,
  output cpu_pkg::writeback_t       wb
);

  logic [cpu_pkg::data_width-1:0] dmem [cpu_pkg::mem_words]; // Data store
  logic [cpu_pkg::addr_width-1:0] mem_index;
  logic [cpu_pkg::data_width-1:0] load_data;
  logic                           retire;                    // Visible register write

  assign mem_index = execute_out.alu_result[cpu_pkg::addr_width:1]; // Byte address to word
  assign load_data = dmem[mem_index];                               // Combinational read

  //////////////////////////////
  // Data memory
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (execute_out.valid && execute_out.mem_write) begin
      dmem[mem_index] <= execute_out.store_data; // SW
    end
  end

  // r0 writes are dropped here
  assign retire = execute_out.valid && execute_out.reg_write
               && execute_out.dst_reg != 4'd0;

  //////////////////////////////
  // Memory/writeback register
  //////////////////////////////
  always_ff @(posedge clk) begin
    wb.dst_reg <= execute_out.dst_reg;
    wb.data    <= execute_out.mem_read ? load_data           // LW
                                       : execute_out.alu_result;
    if (reset) begin
      wb.valid <= 1'b0;
    end else begin
      wb.valid <= retire;
    end
  end

endmodule

// ==== source/execute_unit.sv ====
module execute_unit (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     boot,
  input  cpu_pkg::decode_out_t     decode_out,
  output cpu_pkg::flags_t          flags,
  output cpu_pkg::execute_out_t    execute_out
);

  logic [cpu_pkg::data_width-1:0]   a, b;
  logic [cpu_pkg::data_width-1:0]   result;
  logic [2*cpu_pkg::data_width-1:0] rot;     // Doubled word for rotate
  logic [3:0]                       shamt;
  logic                             ovf;     // Signed overflow of add or sub

  assign a     = decode_out.operand_a;
  assign b     = decode_out.operand_b;
  assign shamt = b[3:0];
  assign rot   = {a, a} >> shamt;

  //////////////////////////////
  // ALU
  //////////////////////////////
  always_comb begin
    case (decode_out.alu_op)
      cpu_pkg::op_sub: result = a - b;                  // Wraps
      cpu_pkg::op_xor: result = a ^ b;
      cpu_pkg::op_sll: result = a << shamt;
      cpu_pkg::op_sra: result = $signed(a) >>> shamt;   // Sign fill
      cpu_pkg::op_ror: result = rot[cpu_pkg::data_width-1:0];
      default:         result = a + b;                  // ADD, address, byte loads
    endcase
  end

  // Operand signs agree for add, differ for sub, result sign flips
  assign ovf = (decode_out.alu_op == cpu_pkg::op_sub)
             ? (a[15] != b[15]) && (result[15] != a[15])
             : (a[15] == b[15]) && (result[15] != a[15]);

  // Flag register
  always_ff @(posedge clk) begin
    if (reset || boot) begin
      flags <= '0;
    end else if (decode_out.valid && decode_out.flag_write) begin
      flags.z <= (result == '0);
      if (!decode_out.flag_z_only) begin
        flags.v <= ovf;
        flags.n <= result[15];
      end
    end
  end

  //////////////////////////////
  // Execute/memory register
  //////////////////////////////
  always_ff @(posedge clk) begin
    execute_out.alu_result <= result;
    execute_out.store_data <= decode_out.store_data;
    execute_out.dst_reg    <= decode_out.dst_reg;
    execute_out.reg_write  <= decode_out.reg_write;
    execute_out.mem_read   <= decode_out.mem_read;
    execute_out.mem_write  <= decode_out.mem_write;
    if (reset || boot) execute_out.valid <= 1'b0;
    else               execute_out.valid <= decode_out.valid;
  end

  // Decode never marks one instruction as both load and store
  one_mem_op : assert property (@(posedge clk) disable iff (reset)
    decode_out.valid |-> !(decode_out.mem_read && decode_out.mem_write))
    else $error("load and store on one instruction");

endmodule

// ==== source/decode_unit.sv ====
module decode_unit (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     boot,
  input  cpu_pkg::fetch_out_t      fetch_out,
  input  cpu_pkg::flags_t          flags,
  input  cpu_pkg::writeback_t      wb,
  output logic                     redirect,
  output logic [15:0]              redirect_pc,
  output logic                     freeze,
  output cpu_pkg::decode_out_t     decode_out
);

  logic [cpu_pkg::data_width-1:0] reg_file [16]; // Entry 0 never written
  cpu_pkg::instr_u                word;
  cpu_pkg::opcode_e               op;
  cpu_pkg::decode_out_t           dec_next;
  logic [cpu_pkg::data_width-1:0] rs_val, rt_val, rd_val;
  logic [cpu_pkg::data_width-1:0] mem_offset;    // sext(imm4) << 1
  logic [cpu_pkg::data_width-1:0] branch_offset; // sext(imm9) << 1
  logic                           dec_valid;
  logic                           halted;
  logic                           cond_true;

  assign word      = fetch_out.word;
  assign op        = word.r_view.op;
  assign dec_valid = fetch_out.valid && !halted; // Word after HLT is dropped

  //////////////////////////////
  // Register file
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (wb.valid && wb.dst_reg != 4'd0) begin
      reg_file[wb.dst_reg] <= wb.data; // Written at the end of the wb cycle
    end
  end

  // No bypass, r0 wired to zero
  assign rs_val = (word.r_view.rs == 4'd0) ? '0 : reg_file[word.r_view.rs];
  assign rt_val = (word.r_view.rt == 4'd0) ? '0 : reg_file[word.r_view.rt];
  assign rd_val = (word.r_view.rd == 4'd0) ? '0 : reg_file[word.r_view.rd];

  assign mem_offset    = {{11{word.i_view.imm4[3]}}, word.i_view.imm4, 1'b0};
  assign branch_offset = {{6{word.branch_view.imm9[8]}}, word.branch_view.imm9, 1'b0};

  //////////////////////////////
  // Control decode
  //////////////////////////////
  always_comb begin
    dec_next            = '0;
    dec_next.valid      = dec_valid;
    dec_next.alu_op     = op;
    dec_next.dst_reg    = word.r_view.rd;
    dec_next.operand_a  = rs_val;
    dec_next.operand_b  = rt_val;
    dec_next.store_data = rd_val;               // SW source
    case (op)
      cpu_pkg::op_add, cpu_pkg::op_sub: begin
        dec_next.reg_write  = 1'b1;
        dec_next.flag_write = 1'b1;             // Z, V and N
      end
      cpu_pkg::op_xor: begin
        dec_next.reg_write   = 1'b1;
        dec_next.flag_write  = 1'b1;
        dec_next.flag_z_only = 1'b1;
      end
      cpu_pkg::op_sll, cpu_pkg::op_sra, cpu_pkg::op_ror: begin
        dec_next.operand_b   = {12'h000, word.i_view.imm4}; // Shift amount
        dec_next.reg_write   = 1'b1;
        dec_next.flag_write  = 1'b1;
        dec_next.flag_z_only = 1'b1;
      end
      cpu_pkg::op_lw: begin
        dec_next.alu_op    = cpu_pkg::op_add;   // Address add
        dec_next.operand_b = mem_offset;
        dec_next.reg_write = 1'b1;
        dec_next.mem_read  = 1'b1;
      end
      cpu_pkg::op_sw: begin
        dec_next.alu_op    = cpu_pkg::op_add;
        dec_next.operand_b = mem_offset;
        dec_next.mem_write = 1'b1;
      end
      cpu_pkg::op_llb: begin
        dec_next.alu_op    = cpu_pkg::op_add;   // Merge of disjoint bytes
        dec_next.operand_a = rd_val & 16'hff00;
        dec_next.operand_b = {8'h00, word.byte_view.imm8};
        dec_next.reg_write = 1'b1;
      end
      cpu_pkg::op_lhb: begin
        dec_next.alu_op    = cpu_pkg::op_add;
        dec_next.operand_a = rd_val & 16'h00ff;
        dec_next.operand_b = {word.byte_view.imm8, 8'h00};
        dec_next.reg_write = 1'b1;
      end
      default: dec_next.valid = 1'b0;           // B, BR, HLT finish here
    endcase
  end

  //////////////////////////////
  // Branch resolution
  //////////////////////////////
  always_comb begin
    case (word.branch_view.cond)
      cpu_pkg::cond_ne: cond_true = !flags.z;
      cpu_pkg::cond_eq: cond_true = flags.z;
      cpu_pkg::cond_gt: cond_true = !flags.z && !flags.n;
      cpu_pkg::cond_lt: cond_true = flags.n;
      cpu_pkg::cond_ge: cond_true = flags.z || !flags.n;
      cpu_pkg::cond_le: cond_true = flags.z || flags.n;
      cpu_pkg::cond_ov: cond_true = flags.v;
      default:          cond_true = 1'b1;      // Unconditional
    endcase
  end

  assign redirect = dec_valid && cond_true && (op == cpu_pkg::op_b || op == cpu_pkg::op_br);
  assign redirect_pc = (op == cpu_pkg::op_br) ? {rs_val[15:1], 1'b0}       // Word aligned
                                              : fetch_out.pc_plus_2 + branch_offset;

  // Sticky halt, cleared only by reset or boot
  always_ff @(posedge clk) begin
    if (reset || boot) begin
      halted <= 1'b0;
    end else if (dec_valid && op == cpu_pkg::op_hlt) begin
      halted <= 1'b1;
    end
  end
  assign freeze = halted;

  // Decode/execute register
  always_ff @(posedge clk) begin
    decode_out <= dec_next;
    if (reset || boot) begin
      decode_out.valid <= 1'b0;
    end
  end

  // Memory stage filters r0 out of every retiring write
  no_r0_write : assert property (@(posedge clk) disable iff (reset)
    wb.valid |-> wb.dst_reg != 4'd0)
    else $error("write to r0 reached the register file");

endmodule

// ==== source/fetch_unit.sv ====
module fetch_unit (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               boot,
  input  logic                               imem_we,
  input  logic [7:0]                         imem_addr,
  input  logic [15:0]                        imem_data,
  input  logic                               redirect,
  input  logic [15:0]                        redirect_pc,
  input  logic                               freeze,
  output logic [15:0]                        pc,
  output cpu_pkg::fetch_out_t                fetch_out
);

  logic [cpu_pkg::data_width-1:0] imem [cpu_pkg::mem_words]; // Instruction store
  logic [cpu_pkg::data_width-1:0] pc_plus_2;
  logic [cpu_pkg::addr_width-1:0] fetch_index;                // Word index of pc

  assign pc_plus_2   = pc + 16'd2;
  assign fetch_index = pc[cpu_pkg::addr_width:1];

  //////////////////////////////
  // Boot write port
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (imem_we) begin
      imem[imem_addr] <= imem_data; // Accepted in any cycle
    end
  end

  //////////////////////////////
  // Program counter
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (reset || boot) begin
      pc <= '0;              // Programs start at 0
    end else if (freeze) begin
      pc <= pc;              // Halted, pc stops
    end else if (redirect) begin
      pc <= redirect_pc;     // Taken branch, after the delay slot fetch
    end else begin
      pc <= pc_plus_2;
    end
  end

  // Fetch/decode register
  always_ff @(posedge clk) begin
    fetch_out.word      <= imem[fetch_index];
    fetch_out.pc_plus_2 <= pc_plus_2;
    fetch_out.valid     <= !(reset || boot || freeze); // Bubbles while loading or halted
  end

  // Branch targets and PC+2 keep word alignment
  pc_even_check : assert property (@(posedge clk) disable iff (reset) pc[0] == 1'b0)
    else $error("pc is odd: %h", pc);

endmodule

// ==== source/cpu_pkg.sv ====
package cpu_pkg;

  //////////////////////////////
  // Sizes
  //////////////////////////////
  localparam int data_width = 16;  // Data word
  localparam int addr_width = 8;   // Word index into a memory
  localparam int mem_words  = 256; // Words per memory

  // Opcode field, instr[15:12]
  typedef enum logic [3:0] {
    op_add = 4'h0,
    op_sub = 4'h1,
    op_xor = 4'h2,
    op_sll = 4'h4,
    op_sra = 4'h5,
    op_ror = 4'h6,
    op_lw  = 4'h8,
    op_sw  = 4'h9,
    op_llb = 4'ha,
    op_lhb = 4'hb,
    op_b   = 4'hc,
    op_br  = 4'hd,
    op_hlt = 4'hf
  } opcode_e;

  // Branch condition field, instr[11:9]
  typedef enum logic [2:0] {
    cond_ne = 3'd0, // Z clear
    cond_eq = 3'd1, // Z set
    cond_gt = 3'd2, // Z and N clear
    cond_lt = 3'd3, // N set
    cond_ge = 3'd4, // Z set or N clear
    cond_le = 3'd5, // Z set or N set
    cond_ov = 3'd6, // V set
    cond_un = 3'd7  // Always
  } cond_e;

  //////////////////////////////
  // Instruction word views
  //////////////////////////////
  typedef struct packed {opcode_e op; logic [3:0] rd; logic [3:0] rs; logic [3:0] rt;} r_view_t;
  typedef struct packed {opcode_e op; logic [3:0] rd; logic [3:0] rs; logic [3:0] imm4;} i_view_t;
  typedef struct packed {opcode_e op; logic [3:0] rd; logic [7:0] imm8;} byte_view_t;
  typedef struct packed {opcode_e op; cond_e cond; logic [8:0] imm9;} branch_view_t;

  typedef union packed {
    r_view_t      r_view;      // ALU register ops
    i_view_t      i_view;      // Shifts, LW, SW
    byte_view_t   byte_view;   // LLB, LHB
    branch_view_t branch_view; // B, BR
  } instr_u;

  typedef struct packed {logic z; logic v; logic n;} flags_t;

  //////////////////////////////
  // Stage registers
  //////////////////////////////
  typedef struct packed {
    instr_u                  word;
    logic [data_width-1:0]   pc_plus_2;
    logic                    valid;
  } fetch_out_t;

  typedef struct packed {
    opcode_e                 alu_op;      // add, sub, xor or a shift
    logic [data_width-1:0]   operand_a;
    logic [data_width-1:0]   operand_b;
    logic [data_width-1:0]   store_data;  // rd value for SW
    logic [3:0]              dst_reg;
    logic                    reg_write;
    logic                    mem_read;
    logic                    mem_write;
    logic                    flag_z_only; // XOR and shifts
    logic                    flag_write;
    logic                    valid;
  } decode_out_t;

  typedef struct packed {
    logic [data_width-1:0]   alu_result;  // Also the memory address
    logic [data_width-1:0]   store_data;
    logic [3:0]              dst_reg;
    logic                    reg_write;
    logic                    mem_read;
    logic                    mem_write;
    logic                    valid;
  } execute_out_t;

  typedef struct packed {
    logic                    valid;
    logic [3:0]              dst_reg;
    logic [data_width-1:0]   data;
  } writeback_t;

endpackage
